//--- control_decoder.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module control_decoder import cpu_pkg::*; (
    input  word_t      id_instruction,
    decode_ctrl_if.src ctrl
);

    opcode_t  opcode;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd;
    funct_t   funct;
    logic     r_type;                                   // opcode 0 family
    logic     r_alu;                                    // supported r-type alu op
    logic     alu_imm;                                  // addi, andi, ori, slti
    logic     is_lw;
    logic     is_beq;
    logic     is_bne;

    assign opcode = id_instruction[31:26];
    assign rs     = id_instruction[25:21];
    assign rt     = id_instruction[20:16];
    assign rd     = id_instruction[15:11];
    assign funct  = id_instruction[5:0];

    assign r_type  = (opcode == `OP_RTYPE);
    assign alu_imm = (opcode == `OP_ADDI) || (opcode == `OP_ANDI) ||
                     (opcode == `OP_ORI)  || (opcode == `OP_SLTI);
    assign is_lw   = (opcode == `OP_LW);
    assign is_beq  = (opcode == `OP_BEQ);
    assign is_bne  = (opcode == `OP_BNE);

    // class flags, one per family
    assign ctrl.store_type  = (opcode == `OP_SW);
    assign ctrl.branch_type = is_beq | is_bne;
    assign ctrl.j_type      = (opcode == `OP_J);
    assign ctrl.jal_type    = (opcode == `OP_JAL);
    assign ctrl.jr_type     = r_type && (funct == `FN_JR);
    assign ctrl.i_type      = alu_imm | is_lw | ctrl.store_type | ctrl.branch_type;

    assign ctrl.mem_control = {is_lw, ctrl.store_type};     // [1] read, [0] write

    // alu op from funct for r-type, from opcode otherwise
    always_comb begin
        ctrl.alu_control = `ALU_ADD;                        // lw/sw address, jumps
        r_alu            = 1'b0;
        if (r_type) begin
            case (funct)
                `FN_ADD: begin ctrl.alu_control = `ALU_ADD; r_alu = 1'b1; end
                `FN_SUB: begin ctrl.alu_control = `ALU_SUB; r_alu = 1'b1; end
                `FN_AND: begin ctrl.alu_control = `ALU_AND; r_alu = 1'b1; end
                `FN_OR:  begin ctrl.alu_control = `ALU_OR;  r_alu = 1'b1; end
                `FN_SLT: begin ctrl.alu_control = `ALU_SLT; r_alu = 1'b1; end
                default: ctrl.alu_control = `ALU_ADD;       // jr and unsupported
            endcase
        end else begin
            case (opcode)
                `OP_ANDI:        ctrl.alu_control = `ALU_AND;
                `OP_ORI:         ctrl.alu_control = `ALU_OR;
                `OP_SLTI:        ctrl.alu_control = `ALU_SLT;
                `OP_BEQ, `OP_BNE: ctrl.alu_control = `ALU_SUB;
                default:         ctrl.alu_control = `ALU_ADD;
            endcase
        end
    end

    // destination: rd, rt, 31 for jal, else the zero register
    always_comb begin
        if (r_alu)                      ctrl.dest_reg = rd;
        else if (alu_imm || is_lw)      ctrl.dest_reg = rt;
        else if (ctrl.jal_type)         ctrl.dest_reg = 5'd31;
        else                            ctrl.dest_reg = '0;
    end

    assign ctrl.reg_write_enable = (ctrl.dest_reg != '0);

    // jump index bits are not register fields
    assign ctrl.src_reg_1 = (ctrl.j_type || ctrl.jal_type) ? '0 : rs;
    assign ctrl.src_reg_2 = (alu_imm || is_lw || ctrl.j_type || ctrl.jal_type) ? '0 : rt;

endmodule

//--- cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

`define ISA_WIDTH          32           // data word, pc and instruction width
`define REGISTER_SIZE      5            // register index width, 32 entries
`define ALU_CONTROL_WIDTH  4
`define ADDRESS_WIDTH      26           // j/jal instruction index field
`define OPCODE_WIDTH       6
`define FUNCT_WIDTH        6
`define IMM_WIDTH          16

`define HAZD_HOLD_BIT      0            // keep id/ex contents
`define HAZD_NO_OP_BIT     1            // bubble into ex

`define OP_RTYPE  6'h00
`define OP_J      6'h02
`define OP_JAL    6'h03
`define OP_BEQ    6'h04
`define OP_BNE    6'h05
`define OP_ADDI   6'h08
`define OP_SLTI   6'h0a
`define OP_ANDI   6'h0c
`define OP_ORI    6'h0d
`define OP_LW     6'h23
`define OP_SW     6'h2b

`define FN_JR     6'h08
`define FN_ADD    6'h20
`define FN_SUB    6'h22
`define FN_AND    6'h24
`define FN_OR     6'h25
`define FN_SLT    6'h2a

`define ALU_AND   4'b0000
`define ALU_OR    4'b0001
`define ALU_ADD   4'b0010
`define ALU_SUB   4'b0110           // also used for branch compare
`define ALU_SLT   4'b0111

`endif

//--- cpu_pkg.sv
`include "cpu_macros.svh"

package cpu_pkg;

    // data word, also pc and raw instruction
    typedef logic [`ISA_WIDTH-1:0]         word_t;

    // register file index, 0 is the hardwired zero register
    typedef logic [`REGISTER_SIZE-1:0]     reg_idx_t;

    typedef logic [`ALU_CONTROL_WIDTH-1:0] alu_ctrl_t;   // alu operation select

    // [0] write, [1] read
    typedef logic [1:0]                    mem_ctrl_t;

    // [HAZD_HOLD_BIT] hold, [HAZD_NO_OP_BIT] bubble
    typedef logic [1:0]                    hazard_t;

    typedef logic [`OPCODE_WIDTH-1:0]      opcode_t;     // instruction bits 31:26
    typedef logic [`FUNCT_WIDTH-1:0]       funct_t;      // r-type bits 5:0
    typedef logic [`IMM_WIDTH-1:0]         imm_t;        // i-type bits 15:0

endpackage

//--- filelist.f
+incdir+.
cpu_pkg.sv
id_ifs.sv
control_decoder.sv
operand_fetch.sv
id_ex_reg.sv
id_stage.sv
id_stage_checker.sv
tb_id_stage.sv

//--- id_ex_reg.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module id_ex_reg import cpu_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  hazard_t           hazard_control,       // hold and bubble requests
    input  logic              id_no_op,             // bubble already in id
    input  word_t             id_pc,
    input  word_t             id_instruction,
    decode_ctrl_if.dst        ctrl,
    decode_data_if.dst        data,
    output logic              ex_no_op,             // alu idles this cycle
    output logic              pc_offset,            // branch taken, redirect fetch
    output logic              pc_overload,          // jump, pc replaced
    output logic              ex_reg_write_enable,
    output mem_ctrl_t         ex_mem_control,
    output alu_ctrl_t         ex_alu_control,
    output word_t             ex_pc,
    output word_t             ex_operand_1,
    output word_t             ex_operand_2,
    output word_t             ex_store_data,        // sw data for mem stage
    output reg_idx_t          ex_src_reg_1,         // for forwarding
    output reg_idx_t          ex_src_reg_2,
    output reg_idx_t          ex_dest_reg
);

    word_t pc_4;
    word_t jump_target;
    logic  jump_abs;                                // j or jal use the target
    logic  use_imm;                                 // i-type other than branch

    assign pc_4        = id_pc + `ISA_WIDTH'd4;
    assign jump_target = {pc_4[`ISA_WIDTH-1:`ADDRESS_WIDTH+2],
                          id_instruction[`ADDRESS_WIDTH-1:0],
                          2'b00};                   // pseudo-direct address
    assign jump_abs    = ctrl.j_type | ctrl.jal_type;
    assign use_imm     = ctrl.i_type & ~ctrl.branch_type;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_offset           <= 1'b0;
            pc_overload         <= 1'b0;
            ex_reg_write_enable <= 1'b0;
            ex_mem_control      <= '0;
            ex_alu_control      <= '0;
            ex_pc               <= '0;
            ex_operand_1        <= '0;
            ex_operand_2        <= '0;
            ex_store_data       <= '0;
            ex_src_reg_1        <= '0;
            ex_src_reg_2        <= '0;
            ex_dest_reg         <= '0;
        end else if (!hazard_control[`HAZD_HOLD_BIT]) begin    // hold keeps everything
            pc_offset           <= ctrl.branch_type & data.condition_satisfied;
            pc_overload         <= jump_abs | ctrl.jr_type;
            ex_reg_write_enable <= ctrl.reg_write_enable;
            ex_mem_control      <= ctrl.mem_control;
            ex_alu_control      <= ctrl.alu_control;
            ex_pc               <= id_pc;
            ex_operand_1        <= jump_abs ? jump_target : data.reg_1;
            ex_operand_2        <= use_imm ? data.sign_extend_result : data.reg_2;
            ex_store_data       <= data.reg_2;
            ex_src_reg_1        <= ctrl.src_reg_1;
            ex_src_reg_2        <= ctrl.src_reg_2;
            ex_dest_reg         <= ctrl.dest_reg;
        end
    end

    // bubble flag reloads every edge, even under hold
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_no_op <= 1'b0;
        end else begin
            ex_no_op <= hazard_control[`HAZD_NO_OP_BIT] | id_no_op;
        end
    end

endmodule

//--- id_ifs.sv
`timescale 1ns/1ps

// decoded control from control_decoder into id_ex_reg
interface decode_ctrl_if import cpu_pkg::*; ();
    logic      i_type;                  // any i-format instruction
    logic      j_type;                  // j only
    logic      jr_type;
    logic      jal_type;
    logic      branch_type;             // beq or bne
    logic      store_type;              // sw
    logic      reg_write_enable;
    mem_ctrl_t mem_control;
    alu_ctrl_t alu_control;
    reg_idx_t  src_reg_1;
    reg_idx_t  src_reg_2;
    reg_idx_t  dest_reg;

    modport src (
        output i_type, j_type, jr_type, jal_type, branch_type, store_type,
        output reg_write_enable, mem_control, alu_control,
        output src_reg_1, src_reg_2, dest_reg
    );
    modport dst (
        input  i_type, j_type, jr_type, jal_type, branch_type, store_type,
        input  reg_write_enable, mem_control, alu_control,
        input  src_reg_1, src_reg_2, dest_reg
    );
endinterface

// register values and immediate from operand_fetch into id_ex_reg
interface decode_data_if import cpu_pkg::*; ();
    word_t reg_1;                       // value of rs
    word_t reg_2;                       // value of rt
    word_t sign_extend_result;
    logic  condition_satisfied;         // branch compare outcome

    modport src (output reg_1, reg_2, sign_extend_result, condition_satisfied);
    modport dst (input  reg_1, reg_2, sign_extend_result, condition_satisfied);
endinterface

//--- id_stage.sv
`timescale 1ns/1ps

module id_stage import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  word_t     id_instruction,
    input  word_t     id_pc,
    input  logic      id_no_op,
    input  hazard_t   hazard_control,
    input  logic      wb_enable,              // write-back port
    input  reg_idx_t  wb_reg,
    input  word_t     wb_data,
    output logic      ex_no_op,
    output logic      pc_offset,
    output logic      pc_overload,
    output logic      ex_reg_write_enable,
    output mem_ctrl_t ex_mem_control,
    output alu_ctrl_t ex_alu_control,
    output word_t     ex_pc,
    output word_t     ex_operand_1,
    output word_t     ex_operand_2,
    output word_t     ex_store_data,
    output reg_idx_t  ex_src_reg_1,
    output reg_idx_t  ex_src_reg_2,
    output reg_idx_t  ex_dest_reg
);

    decode_ctrl_if ctrl_if ();                 // decoder to stage register
    decode_data_if data_if ();                 // operands to stage register

    control_decoder u_control_decoder (
        .id_instruction (id_instruction),
        .ctrl           (ctrl_if)
    );

    operand_fetch u_operand_fetch (
        .clk            (clk),
        .rst_n          (rst_n),
        .id_instruction (id_instruction),
        .wb_enable      (wb_enable),
        .wb_reg         (wb_reg),
        .wb_data        (wb_data),
        .data           (data_if)
    );

    id_ex_reg u_id_ex_reg (
        .clk                 (clk),
        .rst_n               (rst_n),
        .hazard_control      (hazard_control),
        .id_no_op            (id_no_op),
        .id_pc               (id_pc),
        .id_instruction      (id_instruction),
        .ctrl                (ctrl_if),
        .data                (data_if),
        .ex_no_op            (ex_no_op),
        .pc_offset           (pc_offset),
        .pc_overload         (pc_overload),
        .ex_reg_write_enable (ex_reg_write_enable),
        .ex_mem_control      (ex_mem_control),
        .ex_alu_control      (ex_alu_control),
        .ex_pc               (ex_pc),
        .ex_operand_1        (ex_operand_1),
        .ex_operand_2        (ex_operand_2),
        .ex_store_data       (ex_store_data),
        .ex_src_reg_1        (ex_src_reg_1),
        .ex_src_reg_2        (ex_src_reg_2),
        .ex_dest_reg         (ex_dest_reg)
    );

endmodule

//--- id_stage_checker.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module id_stage_checker import cpu_pkg::*; (
    input logic      clk,
    input logic      rst_n,
    input hazard_t   hazard_control,
    input logic      ex_no_op,
    input logic      pc_offset,
    input logic      pc_overload,
    input logic      ex_reg_write_enable,
    input mem_ctrl_t ex_mem_control,
    input word_t     ex_operand_1,
    input word_t     ex_operand_2,
    input reg_idx_t  ex_dest_reg
);

    // every id/ex output is cleared one edge after reset is seen
    a_reset_clears: assert property (@(posedge clk)
        !rst_n |=> (!ex_no_op && !pc_offset && !pc_overload && !ex_reg_write_enable &&
                    (ex_mem_control == '0) && (ex_operand_1 == '0) &&
                    (ex_operand_2 == '0) && (ex_dest_reg == '0)))
        else $error("id/ex outputs not cleared after reset");

    a_hold_keeps_operand: assert property (@(posedge clk) disable iff (!rst_n)
        hazard_control[`HAZD_HOLD_BIT] |=> $stable(ex_operand_1))   // frozen stage
        else $error("ex_operand_1 changed while hold was requested");

    a_dest_needs_write: assert property (@(posedge clk) disable iff (!rst_n)
        (ex_dest_reg != '0) |-> ex_reg_write_enable)    // dest 0 means no write
        else $error("nonzero ex_dest_reg without write enable");

endmodule

//--- id_trace.txt
# name rst_n instr pc hazard id_no_op wb_enable wb_reg wb_data (stimulus, hex)
# then expected: operand_1 operand_2 store_data dest_reg alu_control pc_offset pc_overload no_op reg_write_enable
wb_read  1 00000000 00400000 0 0 1 01 00001234 00000000 00000000 00000000 00 2 0 0 0 0
wb_read  1 00000000 00400004 0 0 1 02 fffffff0 00000000 00000000 00000000 00 2 0 0 0 0
wb_read  1 00221820 00400008 0 0 1 04 0000abcd 00001234 fffffff0 fffffff0 03 2 0 0 0 1
wb_read  1 00c13824 0040000c 0 0 1 06 55aa0000 55aa0000 00001234 00001234 07 0 0 0 0 1
wb_read  1 00804022 00400010 0 0 0 00 00000000 0000abcd 00000000 00000000 08 6 0 0 0 1
wb_read  1 00c44825 00400014 0 0 0 00 00000000 55aa0000 0000abcd 0000abcd 09 1 0 0 0 1
wb_read  1 0041502a 00400018 0 0 0 00 00000000 fffffff0 00001234 00001234 0a 7 0 0 0 1
wb_read  1 00005820 0040001c 0 0 1 00 deadbeef 00000000 00000000 00000000 0b 2 0 0 0 1
imm_sel  1 202cfffc 00400020 0 0 0 00 00000000 00001234 fffffffc 00000000 0c 2 0 0 0 1
imm_sel  1 304d00ff 00400024 0 0 0 00 00000000 fffffff0 000000ff 00000000 0d 0 0 0 0 1
imm_sel  1 348e8001 00400028 0 0 0 00 00000000 0000abcd ffff8001 00000000 0e 1 0 0 0 1
imm_sel  1 282f7fff 0040002c 0 0 0 00 00000000 00001234 00007fff 00000000 0f 7 0 0 0 1
imm_sel  1 8cd00008 00400030 0 0 0 00 00000000 55aa0000 00000008 00000000 10 2 0 0 0 1
imm_sel  1 ac24fff8 00400034 0 0 0 00 00000000 00001234 fffffff8 0000abcd 00 2 0 0 0 0
redirect 1 08100040 00400010 0 0 0 00 00000000 00400100 00000000 00000000 00 2 0 1 0 0
redirect 1 0fffffff a0000000 0 0 0 00 00000000 affffffc 00000000 00000000 1f 2 0 1 0 1
redirect 1 00200008 00400040 0 0 0 00 00000000 00001234 00000000 00000000 00 2 0 1 0 0
redirect 1 10210004 00400044 0 0 0 00 00000000 00001234 00001234 00001234 00 6 1 0 0 0
redirect 1 10220004 00400048 0 0 0 00 00000000 00001234 fffffff0 fffffff0 00 6 0 0 0 0
redirect 1 1422fff0 0040004c 0 0 0 00 00000000 00001234 fffffff0 fffffff0 00 6 1 0 0 0
redirect 1 14210008 00400050 0 0 0 00 00000000 00001234 00001234 00001234 00 6 0 0 0 0
hold     1 00221820 00400054 0 0 0 00 00000000 00001234 fffffff0 fffffff0 03 2 0 0 0 1
hold     1 348e8001 00400058 1 0 0 00 00000000 00001234 fffffff0 fffffff0 03 2 0 0 0 1
hold     1 8cd00008 0040005c 3 0 0 00 00000000 00001234 fffffff0 fffffff0 03 2 0 0 1 1
hold     1 ac24fff8 00400060 2 0 0 00 00000000 00001234 fffffff8 0000abcd 00 2 0 0 1 0
hold     1 0041502a 00400064 0 1 0 00 00000000 fffffff0 00001234 00001234 0a 7 0 0 1 1
hold     1 08100040 00400010 0 0 0 00 00000000 00400100 00000000 00000000 00 2 0 1 0 0
reset    0 00221820 00400068 0 0 0 00 00000000 00000000 00000000 00000000 00 0 0 0 0 0
reset    1 00221820 0040006c 0 0 0 00 00000000 00000000 00000000 00000000 03 2 0 0 0 1
reset    1 00221820 00400070 0 0 1 01 00000077 00000077 00000000 00000000 03 2 0 0 0 1

//--- operand_fetch.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module operand_fetch import cpu_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  word_t         id_instruction,
    input  logic          wb_enable,
    input  reg_idx_t      wb_reg,
    input  word_t         wb_data,
    decode_data_if.src    data
);

    localparam int NUM_REGS = 1 << `REGISTER_SIZE;

    word_t    regs [NUM_REGS];                          // general purpose registers
    opcode_t  opcode;
    reg_idx_t rs;
    reg_idx_t rt;
    imm_t     imm;
    logic     wb_active;                                // real write this cycle
    word_t    rd_val_1;
    word_t    rd_val_2;

    assign opcode = id_instruction[31:26];
    assign rs     = id_instruction[25:21];
    assign rt     = id_instruction[20:16];
    assign imm    = id_instruction[15:0];

    assign wb_active = wb_enable && (wb_reg != '0);    // r0 never written

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_active) begin
            regs[wb_reg] <= wb_data;
        end
    end

    // read ports with write-back bypass, r0 hardwired to zero
    assign rd_val_1 = (rs == '0)                     ? '0      :
                      (wb_active && (wb_reg == rs))  ? wb_data :
                                                       regs[rs];
    assign rd_val_2 = (rt == '0)                     ? '0      :
                      (wb_active && (wb_reg == rt))  ? wb_data :
                                                       regs[rt];

    assign data.reg_1 = rd_val_1;
    assign data.reg_2 = rd_val_2;

    assign data.sign_extend_result = {{(`ISA_WIDTH - `IMM_WIDTH){imm[`IMM_WIDTH-1]}}, imm};

    // branch compare on the bypassed values
    always_comb begin
        case (opcode)
            `OP_BEQ: data.condition_satisfied = (rd_val_1 == rd_val_2);
            `OP_BNE: data.condition_satisfied = (rd_val_1 != rd_val_2);
            default: data.condition_satisfied = 1'b0;
        endcase
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# build the id stage testbench with verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module tb_id_stage -f filelist.f -o sim_id_stage; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/sim_id_stage > sim.log 2>&1; then
    cat sim.log
    echo "simulation exited with an error status"
    exit 1
fi

cat sim.log
if grep -q "^Verification passed$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- tb_id_stage.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module tb_id_stage import cpu_pkg::*; ();

    localparam int MAX_LINES = 64;
    localparam logic [127:0] IDLE_TAG = 128'("idle");

    // one trace line, stimulus first, then the expected id/ex contents
    typedef struct packed {
        logic [127:0] tag;                      // test name, also the group key
        logic         rst_n;
        word_t        instr;
        word_t        pc;
        hazard_t      hazard;
        logic         no_op;
        logic         wb_en;
        reg_idx_t     wb_reg;
        word_t        wb_data;
        word_t        op1;
        word_t        op2;
        word_t        store;
        reg_idx_t     dest;
        alu_ctrl_t    alu;
        logic         offset;
        logic         overload;
        logic         exp_no_op;
        logic         we;
    } trace_line_t;

    logic      clk;
    logic      rst_n;
    word_t     id_instruction;
    word_t     id_pc;
    logic      id_no_op;
    hazard_t   hazard_control;
    logic      wb_enable;
    reg_idx_t  wb_reg;
    word_t     wb_data;
    logic      ex_no_op;
    logic      pc_offset;
    logic      pc_overload;
    logic      ex_reg_write_enable;
    mem_ctrl_t ex_mem_control;
    alu_ctrl_t ex_alu_control;
    word_t     ex_pc;
    word_t     ex_operand_1;
    word_t     ex_operand_2;
    word_t     ex_store_data;
    reg_idx_t  ex_src_reg_1;
    reg_idx_t  ex_src_reg_2;
    reg_idx_t  ex_dest_reg;

    trace_line_t lines [MAX_LINES];
    int          num_lines;
    int          errors;
    int          checks;
    int          cycles = 0;                    // watchdog count
    int          cycle_limit = 0;               // 0 until the trace is loaded

    word_t     exp_pc;                          // modeled ex_pc, follows hold and reset
    mem_ctrl_t exp_mem;
    reg_idx_t  exp_src_1;
    reg_idx_t  exp_src_2;

    id_stage i_id_stage (.*);

    bind id_stage id_stage_checker i_id_stage_checker (
        .clk                 (clk),
        .rst_n               (rst_n),
        .hazard_control      (hazard_control),
        .ex_no_op            (ex_no_op),
        .pc_offset           (pc_offset),
        .pc_overload         (pc_overload),
        .ex_reg_write_enable (ex_reg_write_enable),
        .ex_mem_control      (ex_mem_control),
        .ex_operand_1        (ex_operand_1),
        .ex_operand_2        (ex_operand_2),
        .ex_dest_reg         (ex_dest_reg)
    );

    always #20 clk = ~clk;                      // 40 ns period

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if ((cycle_limit > 0) && (cycles >= cycle_limit)) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic check_value(input logic [127:0] tag, input string field,
                               input word_t expected, input word_t actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[ERROR] %0s %0s: expected %h, actual %h", tag, field, expected, actual);
        end
    endtask

    // pc, memory control and source indices are not in the trace, modeled here
    task automatic predict_side(input logic rst_n_in, input hazard_t hz,
                                input word_t instr, input word_t pc);
        opcode_t op;
        op = instr[31:26];
        if (!rst_n_in) begin
            exp_pc    = '0;
            exp_mem   = '0;
            exp_src_1 = '0;
            exp_src_2 = '0;
        end else if (!hz[`HAZD_HOLD_BIT]) begin
            exp_pc  = pc;
            exp_mem = (op == `OP_LW) ? 2'b10 : ((op == `OP_SW) ? 2'b01 : 2'b00);
            case (op)
                `OP_J, `OP_JAL: begin               // no register fields
                    exp_src_1 = '0;
                    exp_src_2 = '0;
                end
                `OP_ADDI, `OP_ANDI, `OP_ORI, `OP_SLTI, `OP_LW: begin
                    exp_src_1 = instr[25:21];
                    exp_src_2 = '0;                 // rt is the destination
                end
                default: begin
                    exp_src_1 = instr[25:21];
                    exp_src_2 = instr[20:16];
                end
            endcase
        end
    endtask

    task automatic compare_side(input logic [127:0] tag);
        check_value(tag, "ex_pc", exp_pc, ex_pc);
        check_value(tag, "ex_mem_control", 32'(exp_mem), 32'(ex_mem_control));
        check_value(tag, "ex_src_reg_1", 32'(exp_src_1), 32'(ex_src_reg_1));
        check_value(tag, "ex_src_reg_2", 32'(exp_src_2), 32'(ex_src_reg_2));
    endtask

    // '#' lines are headers, every other line carries 17 hex fields after the name
    task automatic load_trace(output logic ok);
        int           fd;
        int           code;
        int           ch;
        logic [127:0] tag;
        word_t        f [17];
        ok        = 1'b1;
        num_lines = 0;
        fd        = $fopen("id_trace.txt", "r");
        if (fd == 0) begin
            ok = 1'b0;
        end else begin
            while (ok && ($fscanf(fd, "%s", tag) == 1)) begin
                if (tag == 128'("#")) begin
                    ch = $fgetc(fd);
                    while ((ch != 10) && (ch != -1)) begin   // rest of header line
                        ch = $fgetc(fd);
                    end
                end else begin
                    code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                   f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                                   f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16]);
                    if ((code != 17) || (num_lines >= MAX_LINES)) begin
                        ok = 1'b0;
                    end else begin
                        lines[num_lines] = '{tag, f[0][0], f[1], f[2], f[3][1:0], f[4][0],
                                             f[5][0], f[6][4:0], f[7], f[8], f[9], f[10],
                                             f[11][4:0], f[12][3:0], f[13][0], f[14][0],
                                             f[15][0], f[16][0]};
                        num_lines++;
                    end
                end
            end
            $fclose(fd);
            if (num_lines == 0) begin
                ok = 1'b0;
            end
        end
    endtask

    task automatic apply_line(input trace_line_t ln);
        rst_n          = ln.rst_n;
        id_instruction = ln.instr;
        id_pc          = ln.pc;
        hazard_control = ln.hazard;
        id_no_op       = ln.no_op;
        wb_enable      = ln.wb_en;
        wb_reg         = ln.wb_reg;
        wb_data        = ln.wb_data;
        predict_side(ln.rst_n, ln.hazard, ln.instr, ln.pc);
    endtask

    task automatic compare_line(input trace_line_t ln);
        check_value(ln.tag, "ex_operand_1", ln.op1, ex_operand_1);
        check_value(ln.tag, "ex_operand_2", ln.op2, ex_operand_2);
        check_value(ln.tag, "ex_store_data", ln.store, ex_store_data);
        check_value(ln.tag, "ex_dest_reg", 32'(ln.dest), 32'(ex_dest_reg));
        check_value(ln.tag, "ex_alu_control", 32'(ln.alu), 32'(ex_alu_control));
        check_value(ln.tag, "pc_offset", 32'(ln.offset), 32'(pc_offset));
        check_value(ln.tag, "pc_overload", 32'(ln.overload), 32'(pc_overload));
        check_value(ln.tag, "ex_no_op", 32'(ln.exp_no_op), 32'(ex_no_op));
        check_value(ln.tag, "ex_reg_write_enable", 32'(ln.we), 32'(ex_reg_write_enable));
        compare_side(ln.tag);
    endtask

    // bubble between groups, nop instruction and no write-back
    task automatic idle_cycle();
        rst_n          = 1'b1;
        id_instruction = '0;
        id_pc          = '0;
        hazard_control = '0;
        id_no_op       = 1'b1;
        wb_enable      = 1'b0;
        wb_reg         = '0;
        wb_data        = '0;
        predict_side(1'b1, '0, '0, '0);
        @(posedge clk);
        #2;
        check_value(IDLE_TAG, "ex_no_op", 32'd1, 32'(ex_no_op));
        check_value(IDLE_TAG, "ex_reg_write_enable", 32'd0, 32'(ex_reg_write_enable));
        check_value(IDLE_TAG, "pc_offset", 32'd0, 32'(pc_offset));
        check_value(IDLE_TAG, "pc_overload", 32'd0, 32'(pc_overload));
        compare_side(IDLE_TAG);
    endtask

    initial begin
        logic ok;
        int   idle;
        clk            = 1'b0;
        rst_n          = 1'b0;                  // held low through 4 edges
        id_instruction = '0;
        id_pc          = '0;
        id_no_op       = 1'b0;
        hazard_control = '0;
        wb_enable      = 1'b0;
        wb_reg         = '0;
        wb_data        = '0;
        errors         = 0;
        checks         = 0;
        void'($urandom(64737));
        load_trace(ok);
        if (!ok) begin
            $display("id_trace.txt is missing, empty or malformed, run stopped");
            $display("Verification failed");
            $finish;
        end else begin
            cycle_limit = 4 * num_lines + 50;
            repeat (4) @(posedge clk);
            #2;                                 // first line also releases reset
            for (int i = 0; i < num_lines; i++) begin
                if ((i > 0) && (lines[i].tag != lines[i-1].tag)) begin
                    idle = 1 + ($urandom % 3);  // at least one bubble per group change
                    repeat (idle) idle_cycle();
                end
                apply_line(lines[i]);
                @(posedge clk);
                #2;                             // outputs settled, next drive follows
                compare_line(lines[i]);
            end
            $display("checks run: %0d, errors: %0d", checks, errors);
            if (errors == 0) begin
                $display("Verification passed");
            end else begin
                $display("Verification failed");
            end
            $finish;
        end
    end

endmodule
